//--- include/mac_settings.svh
// Multiply-add unit settings

`ifndef MAC_SETTINGS_SVH
`define MAC_SETTINGS_SVH

// ----------------------------------------------------------------------
// Datapath widths
// ----------------------------------------------------------------------

// Width of each signed multiplier operand
`define MAC_OP_W 16

// Width of the signed addend, the product and the saturated result
`define MAC_ACC_W 32

// Width of the sideband tag that rides along with each beat
`define MAC_TAG_W 8

// ----------------------------------------------------------------------
// Pipeline depths
// ----------------------------------------------------------------------

// Register depth of the multiplier: operands, partial products, sum
// The alignment delay lines must match this depth exactly
`define MAC_MUL_STAGES 3

// Input to output latency, the multiplier plus the registered adder
`define MAC_LATENCY (`MAC_MUL_STAGES + 1)

`endif

//--- source/mac_pkg.sv
// Multiply-add shared types

`default_nettype none

`include "mac_settings.svh"

package mac_pkg;

  // ----------------------------------------------------------------------
  // Scalar types
  // ----------------------------------------------------------------------

  // One signed multiplier operand
  typedef logic signed [`MAC_OP_W-1:0] opT;

  // Signed addend, full product or saturated result
  typedef logic signed [`MAC_ACC_W-1:0] accT;

  // Opaque tag, passed through untouched
  typedef logic [`MAC_TAG_W-1:0] tagT;

  // ----------------------------------------------------------------------
  // Beat types
  // ----------------------------------------------------------------------

  // Input beat as presented at the top level, 72 bits
  typedef struct packed {
    opT  a;
    opT  b;
    accT c;
    tagT tag;
  } macInT;

  // Sideband that waits beside the multiplier, 40 bits
  // Only the addend and the tag need to be aligned with the product
  typedef struct packed {
    accT c;
    tagT tag;
  } alignT;

  // Output beat, 41 bits
  // The sat flag is set when the result was clamped to a bound
  typedef struct packed {
    accT  result;
    logic sat;
    tagT  tag;
  } macOutT;

endpackage : mac_pkg

`default_nettype wire

//--- source/delay_nr.sv
// Delay line without reset

`timescale 1ns/1ps
`default_nettype none

module delay_nr #(
  // Payload carried through the line, any packed type
  parameter type PayloadT = logic,
  // Number of register stages, zero gives a plain wire
  parameter int NumStages = 0
) (
  // Rising edge clock that a zero-stage line never reads
  input  wire logic    clk,
  input  wire PayloadT in,
  // Input as it was NumStages cycles ago
  output PayloadT      out
);

  // ----------------------------------------------------------------------
  // Elaboration checks
  // ----------------------------------------------------------------------

  if (NumStages < 0) begin : genBadStages
    $error("delay_nr: NumStages must be zero or more");
  end

  // ----------------------------------------------------------------------
  // Register chain
  // ----------------------------------------------------------------------

  // Entry zero is the input itself, entry i is the output of stage i
  PayloadT stages [NumStages+1];

  assign stages[0] = in;

  // Data only passes through here, so the stages hold whatever they
  // captured and are simply overwritten once traffic starts
  for (genvar i = 1; i <= NumStages; i++) begin : genStages
    always_ff @(posedge clk) begin
      stages[i] <= stages[i-1];
    end
  end

  assign out = stages[NumStages];

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------

  if (NumStages > 0) begin : genDelayCheck
    // The leading delay keeps the check quiet until the chain has been
    // filled once after the start of simulation
    delayMatchA: assert property (
      @(posedge clk) ##NumStages (out === $past(in, NumStages))
    ) else $error("delay_nr: output does not match input from %0d cycles ago",
                  NumStages);
  end

endmodule : delay_nr

`default_nettype wire

//--- source/delay_valid.sv
// Valid strobe delay line

`timescale 1ns/1ps
`default_nettype none

module delay_valid #(
  // Number of register stages, zero gives a plain wire
  parameter int NumStages = 0
) (
  input  wire logic clk,
  // Synchronous, active low
  input  wire logic rstN,
  input  wire logic in,
  output logic      out
);

  // ----------------------------------------------------------------------
  // Elaboration checks
  // ----------------------------------------------------------------------

  if (NumStages < 0) begin : genBadStages
    $error("delay_valid: NumStages must be zero or more");
  end

  // ----------------------------------------------------------------------
  // Register chain
  // ----------------------------------------------------------------------

  // Bit zero is the input, bit i is the output of stage i
  logic [NumStages:0] stages;

  assign stages[0] = in;

  // Every stage clears on reset so no stale strobe leaks out afterwards
  for (genvar i = 1; i <= NumStages; i++) begin : genStages
    always_ff @(posedge clk) begin
      if (!rstN) begin
        stages[i] <= 1'b0;
      end else begin
        stages[i] <= stages[i-1];
      end
    end
  end

  assign out = stages[NumStages];

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------

  if (NumStages > 0) begin : genChecks
    // A reset cycle flushes the whole chain in one edge
    quietAfterResetA: assert property (
      @(posedge clk) !rstN |=> !out
    ) else $error("delay_valid: strobe seen right after reset");

    // After NumStages clean edges the chain holds only real input history
    delayMatchA: assert property (
      @(posedge clk) rstN [*NumStages] ##1 1'b1 |-> (out == $past(in, NumStages))
    ) else $error("delay_valid: strobe does not match input history");
  end

endmodule : delay_valid

`default_nettype wire

//--- source/mult_pipe.sv
// Pipelined signed multiplier

`timescale 1ns/1ps
`default_nettype none

`include "mac_settings.svh"

module mult_pipe
  import mac_pkg::*;
(
  input  wire logic clk,
  input  wire opT   a,
  input  wire opT   b,
  // Full signed product, three cycles after the operands
  output accT       product
);

  localparam int OpW   = `MAC_OP_W;
  localparam int AccW  = `MAC_ACC_W;
  localparam int HalfW = OpW / 2;

  // The shift and sum below assume the product exactly fills the result
  if (AccW != 2 * OpW) begin : genBadWidth
    $error("mult_pipe: result width must be twice the operand width");
  end

  // ----------------------------------------------------------------------
  // Stage 1, operand registers
  // ----------------------------------------------------------------------

  opT aReg;
  opT bReg;

  always_ff @(posedge clk) begin
    aReg <= a;
    bReg <= b;
  end

  // ----------------------------------------------------------------------
  // Stage 2, partial products
  // ----------------------------------------------------------------------

  // High bytes keep the sign, low bytes are plain magnitudes
  logic signed [HalfW-1:0] aHi;
  logic signed [HalfW-1:0] bHi;
  logic        [HalfW-1:0] aLo;
  logic        [HalfW-1:0] bLo;

  assign aHi = aReg[OpW-1:HalfW];
  assign bHi = bReg[OpW-1:HalfW];
  assign aLo = aReg[HalfW-1:0];
  assign bLo = bReg[HalfW-1:0];

  // Mixed terms get a zero bit on the low byte so it stays positive
  logic signed [OpW-1:0] ppHh;
  logic signed [OpW:0]   ppHl;
  logic signed [OpW:0]   ppLh;
  logic        [OpW-1:0] ppLl;

  always_ff @(posedge clk) begin
    ppHh <= aHi * bHi;
    ppHl <= aHi * $signed({1'b0, bLo});
    ppLh <= $signed({1'b0, aLo}) * bHi;
    ppLl <= aLo * bLo;
  end

  // ----------------------------------------------------------------------
  // Stage 3, shift and sum
  // ----------------------------------------------------------------------

  // Each term is aligned to its byte weight and widened to the result
  accT hhTerm;
  accT hlTerm;
  accT lhTerm;
  accT llTerm;

  assign hhTerm = {ppHh, {OpW{1'b0}}};
  assign hlTerm = {{(AccW-OpW-HalfW-1){ppHl[OpW]}}, ppHl, {HalfW{1'b0}}};
  assign lhTerm = {{(AccW-OpW-HalfW-1){ppLh[OpW]}}, ppLh, {HalfW{1'b0}}};
  assign llTerm = {{OpW{1'b0}}, ppLl};

  always_ff @(posedge clk) begin
    product <= hhTerm + hlTerm + lhTerm + llTerm;
  end

  // Byte split and reassembly must give the plain signed product
  productA: assert property (
    @(posedge clk) ##(`MAC_MUL_STAGES)
      (product == accT'($past(a, `MAC_MUL_STAGES)) * accT'($past(b, `MAC_MUL_STAGES)))
  ) else $error("mult_pipe: product mismatch");

endmodule : mult_pipe

`default_nettype wire

//--- source/add_stage.sv
// Saturating add stage

`timescale 1ns/1ps
`default_nettype none

`include "mac_settings.svh"

module add_stage
  import mac_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rstN,
  // Strobe aligned with product and align
  input  wire logic  inValid,
  input  wire accT   product,
  input  wire alignT align,
  output logic       outValid,
  output macOutT     outBeat
);

  localparam int AccW = `MAC_ACC_W;

  // Clamp bounds of the signed result
  localparam accT MaxVal = {1'b0, {(AccW-1){1'b1}}};
  localparam accT MinVal = {1'b1, {(AccW-1){1'b0}}};

  // ----------------------------------------------------------------------
  // Wide sum and clamp
  // ----------------------------------------------------------------------

  // One extra bit of headroom holds any sum of two results exactly
  logic signed [AccW:0] sum;

  assign sum = {product[AccW-1], product} + {align.c[AccW-1], align.c};

  // The two top bits disagree only when the sum left the result range
  logic posOvf;
  logic negOvf;

  assign posOvf = !sum[AccW] && sum[AccW-1];
  assign negOvf = sum[AccW] && !sum[AccW-1];

  accT satSum;

  always_comb begin
    if (posOvf) begin
      satSum = MaxVal;
    end else if (negOvf) begin
      satSum = MinVal;
    end else begin
      satSum = sum[AccW-1:0];
    end
  end

  // ----------------------------------------------------------------------
  // Output registers
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    outBeat.result <= satSum;
    outBeat.sat    <= posOvf || negOvf;
    outBeat.tag    <= align.tag;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      outValid <= 1'b0;
    end else begin
      outValid <= inValid;
    end
  end

  // A flagged beat must sit exactly on one of the clamp bounds
  satBoundA: assert property (
    @(posedge clk) (outValid && outBeat.sat) |->
      (outBeat.result == MaxVal || outBeat.result == MinVal)
  ) else $error("add_stage: saturation flag set on an unclamped result");

endmodule : add_stage

`default_nettype wire

//--- source/mac_top.sv
// Streaming multiply-add top level

`timescale 1ns/1ps
`default_nettype none

`include "mac_settings.svh"

module mac_top
  import mac_pkg::*;
(
  input  wire logic  clk,
  // Synchronous, active low
  input  wire logic  rstN,
  // One beat is taken on every edge where this is high
  input  wire logic  inValid,
  input  wire macInT inBeat,
  // High for one cycle per accepted beat, MAC_LATENCY cycles later
  output logic       outValid,
  output macOutT     outBeat
);

  // ----------------------------------------------------------------------
  // Internal wires
  // ----------------------------------------------------------------------

  // Sideband packed at the input and delayed beside the multiplier
  alignT alignIn;
  alignT alignOut;

  // Product and strobe as they reach the adder
  accT  product;
  logic mulValid;

  assign alignIn = '{c: inBeat.c, tag: inBeat.tag};

  // ----------------------------------------------------------------------
  // Multiplier and alignment
  // ----------------------------------------------------------------------

  mult_pipe iMult (
    .clk     (clk),
    .a       (inBeat.a),
    .b       (inBeat.b),
    .product (product)
  );

  // Addend and tag take the same number of edges as the multiplier
  delay_nr #(
    .PayloadT  (alignT),
    .NumStages (`MAC_MUL_STAGES)
  ) iAlignDelay (
    .clk (clk),
    .in  (alignIn),
    .out (alignOut)
  );

  // The strobe gets its own reset chain so nothing false appears
  // while the data registers still hold junk
  delay_valid #(
    .NumStages (`MAC_MUL_STAGES)
  ) iValidDelay (
    .clk  (clk),
    .rstN (rstN),
    .in   (inValid),
    .out  (mulValid)
  );

  // ----------------------------------------------------------------------
  // Saturating adder
  // ----------------------------------------------------------------------

  add_stage iAdd (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (mulValid),
    .product  (product),
    .align    (alignOut),
    .outValid (outValid),
    .outBeat  (outBeat)
  );

  // Every accepted beat leaves with its own tag after the full latency,
  // which ties the three parallel paths together
  latencyTagA: assert property (
    @(posedge clk) disable iff (!rstN)
      inValid |-> ##(`MAC_LATENCY)
        (outValid && outBeat.tag == $past(inBeat.tag, `MAC_LATENCY))
  ) else $error("mac_top: beat lost or tag misaligned at the output");

endmodule : mac_top

`default_nettype wire

//--- tb/mac_tb.sv
// Multiply-add testbench

`timescale 1ns/1ps
`default_nettype none

`include "mac_settings.svh"

module mac_tb
  import mac_pkg::*;
;

  // ----------------------------------------------------------------------
  // Clock, reset and DUT
  // ----------------------------------------------------------------------

  logic   clk;
  logic   rstN;
  logic   inValid;
  macInT  inBeat;
  logic   outValid;
  macOutT outBeat;

  // Rising edges seen so far, the time base for the latency check
  int cycleCnt = 0;

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycleCnt <= cycleCnt + 1;
  end

  mac_top i_dut (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .inBeat   (inBeat),
    .outValid (outValid),
    .outBeat  (outBeat)
  );

  // ----------------------------------------------------------------------
  // Scoreboard state
  // ----------------------------------------------------------------------

  // Expected beats in flight, with the edge that accepted each one
  macOutT expQ[$];
  int     edgeQ[$];
  string  nameQ[$];

  int sentCnt = 0;
  int outCnt = 0;
  int dataErrors = 0;
  int protoErrors = 0;
  int timeouts = 0;

  logic [31:0] lfsr = 32'h8212_c58d;

  // ----------------------------------------------------------------------
  // Stimulus and reference
  // ----------------------------------------------------------------------

  // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic macInT randomBeat();
    macInT beat;
    beat.a = takeBits(`MAC_OP_W);
    beat.b = takeBits(`MAC_OP_W);
    beat.c = takeBits(`MAC_ACC_W);
    beat.tag = takeBits(`MAC_TAG_W);
    return beat;
  endfunction

  // Exact product plus addend in 64 bits, then clamped to the result range
  function automatic macOutT refMac(input opT a, input opT b, input accT c, input tagT tag);
    macOutT res;
    longint full;
    longint maxV;
    longint minV;
    maxV = (longint'(1) <<< (`MAC_ACC_W - 1)) - 1;
    minV = -(longint'(1) <<< (`MAC_ACC_W - 1));
    full = longint'(a) * longint'(b) + longint'(c);
    res.tag = tag;
    if (full > maxV) begin
      res.result = maxV[`MAC_ACC_W-1:0];
      res.sat = 1'b1;
    end else if (full < minV) begin
      res.result = minV[`MAC_ACC_W-1:0];
      res.sat = 1'b1;
    end else begin
      res.result = full[`MAC_ACC_W-1:0];
      res.sat = 1'b0;
    end
    return res;
  endfunction

  // Drives one beat for a cycle; the next rising edge accepts it
  task automatic sendBeat(input macInT beat, input string name);
    inValid = 1'b1;
    inBeat = beat;
    expQ.push_back(refMac(beat.a, beat.b, beat.c, beat.tag));
    edgeQ.push_back(cycleCnt + 1);
    nameQ.push_back(name);
    sentCnt++;
    @(posedge clk);
    #1;
  endtask

  task automatic idleCycle();
    inValid = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic checkQuiet(input string name);
    assert (outValid === 1'b0) else begin
      protoErrors++;
      $display("[ERROR] %s outValid: expected 0, actual %b", name, outValid);
    end
  endtask

  // Waits until every beat has come out, then matches the pulse count
  task automatic finishTest(input string name, input int sentBase, input int outBase);
    int n;
    n = 0;
    inValid = 1'b0;
    while (expQ.size() != 0 && n < 4 * `MAC_LATENCY) begin
      @(posedge clk);
      #1;
      n++;
    end
    assert (expQ.size() == 0) else begin
      timeouts++;
      $display("Timeout in %s: %0d beats never came out", name, expQ.size());
    end
    assert ((outCnt - outBase) == (sentCnt - sentBase)) else begin
      protoErrors++;
      $display("[ERROR] %s pulses: expected %0d, actual %0d", name,
               sentCnt - sentBase, outCnt - outBase);
    end
  endtask

  // ----------------------------------------------------------------------
  // Compare process
  // ----------------------------------------------------------------------

  // Outputs settle after the rising edge, so they are read on the falling one
  always @(negedge clk) begin : compareProc
    macOutT exp;
    int     acceptEdge;
    string  name;
    if (outValid === 1'b1) begin
      outCnt++;
      assert (expQ.size() != 0) else begin
        protoErrors++;
        $display("Extra outValid pulse at cycle %0d with no beat in flight", cycleCnt);
      end
      if (expQ.size() != 0) begin
        exp = expQ.pop_front();
        acceptEdge = edgeQ.pop_front();
        name = nameQ.pop_front();
        // The consumer takes the beat on the rising edge after it appears
        assert (cycleCnt + 1 - acceptEdge == `MAC_LATENCY) else begin
          dataErrors++;
          $display("[ERROR] %s latency: expected %0d, actual %0d", name,
                   `MAC_LATENCY, cycleCnt + 1 - acceptEdge);
        end
        assert (outBeat.result === exp.result) else begin
          dataErrors++;
          $display("[ERROR] %s result: expected %0d, actual %0d", name,
                   exp.result, outBeat.result);
        end
        assert (outBeat.sat === exp.sat) else begin
          dataErrors++;
          $display("[ERROR] %s sat: expected %b, actual %b", name, exp.sat, outBeat.sat);
        end
        assert (outBeat.tag === exp.tag) else begin
          dataErrors++;
          $display("[ERROR] %s tag: expected 'h%h, actual 'h%h", name, exp.tag, outBeat.tag);
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------

  initial begin : mainProc
    int    sentBase;
    int    outBase;
    macInT beat;
    clk = 1'b0;
    rstN = 1'b0;
    inValid = 1'b0;
    inBeat = '0;

    // Reset quiet, during the three reset cycles and the four after them
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      #1;
      checkQuiet("reset_quiet");
    end
    rstN = 1'b1;
    for (int i = 0; i < `MAC_LATENCY; i++) begin
      @(posedge clk);
      #1;
      checkQuiet("reset_quiet");
    end

    // One lone beat
    sentBase = sentCnt;
    outBase = outCnt;
    beat = '{a: 16'sd1234, b: -16'sd77, c: 32'sd5000, tag: 8'h5a};
    sendBeat(beat, "fixed_latency");
    finishTest("fixed_latency", sentBase, outBase);

    // Back to back at full rate
    sentBase = sentCnt;
    outBase = outCnt;
    for (int i = 0; i < 200; i++) begin
      sendBeat(randomBeat(), "full_rate");
    end
    finishTest("full_rate", sentBase, outBase);

    // One LFSR bit per cycle decides whether a beat goes in
    sentBase = sentCnt;
    outBase = outCnt;
    for (int i = 0; i < 200; i++) begin
      if (takeBits(1) == 1) begin
        sendBeat(randomBeat(), "gapped");
      end else begin
        idleCycle();
      end
    end
    finishTest("gapped", sentBase, outBase);

    // Both clamp bounds, the exact upper bound and a small value
    sentBase = sentCnt;
    outBase = outCnt;
    beat = '{a: -16'sd32768, b: -16'sd32768, c: 32'sh7fff_ffff, tag: 8'h01};
    sendBeat(beat, "saturation");
    beat = '{a: 16'sd32767, b: 16'sd32767, c: 32'sh4000_0000, tag: 8'h02};
    sendBeat(beat, "saturation");
    beat = '{a: -16'sd32768, b: 16'sd32767, c: 32'sh8000_0000, tag: 8'h03};
    sendBeat(beat, "saturation");
    beat = '{a: -16'sd32768, b: -16'sd32768, c: 32'sh3fff_ffff, tag: 8'h04};
    sendBeat(beat, "saturation");
    beat = '{a: 16'sd3, b: -16'sd5, c: 32'sd100, tag: 8'h05};
    sendBeat(beat, "saturation");
    finishTest("saturation", sentBase, outBase);

    assert (expQ.size() == 0) else begin
      protoErrors++;
      $display("Scoreboard still holds %0d beats at the end", expQ.size());
    end

    $display("Errors: data %0d, protocol %0d, timeouts %0d", dataErrors, protoErrors, timeouts);
    if (dataErrors + protoErrors + timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule : mac_tb

`default_nettype wire

//--- src.f
+incdir+include
source/mac_pkg.sv
source/delay_nr.sv
source/delay_valid.sv
source/mult_pipe.sv
source/add_stage.sv
source/mac_top.sv
tb/mac_tb.sv
